// File: rvFrontEnd_tests.txt
// columns stallF stallD flushD pcSrcE pcTargetE then expected pcD instrD immExtD validD
// inputs go in at a falling edge and the expected values hold after the next rising edge
0 0 0 0 00000000 00000000 00500093 00000005 1 // first word after reset
0 0 0 0 00000000 00000004 12345137 12345000 1 // lui
0 0 0 0 00000000 00000008 fe112c23 fffffff8 1 // sw with negative offset
0 0 0 0 00000000 0000000c 00412183 00000004 1 // lw
0 0 0 0 00000000 00000010 00308663 0000000c 1 // beq forward
0 0 0 0 00000000 00000014 00308233 00000000 1 // add has no immediate
0 0 1 1 0000001c 00000000 00000013 00000000 0 // beq taken
0 0 0 0 00000000 0000001c fff30313 ffffffff 1
0 0 0 0 00000000 00000020 fe1ff06f ffffffe0 1 // jal back
0 0 0 0 00000000 00000024 00808067 00000008 1 // jalr
0 0 1 1 00000000 00000000 00000013 00000000 0 // jal taken
0 0 0 0 00000000 00000000 00500093 00000005 1
0 0 0 0 00000000 00000004 12345137 12345000 1
1 1 0 0 00000000 00000004 12345137 12345000 1 // stall both stages
1 1 0 0 00000000 00000004 12345137 12345000 1
0 0 0 0 00000000 00000008 fe112c23 fffffff8 1 // resume without a gap
0 0 0 0 00000000 0000000c 00412183 00000004 1
1 0 1 1 00000018 00000000 00000013 00000000 0 // redirect under stallF
0 0 0 0 00000000 00000018 00001297 00001000 1 // auipc
0 0 0 0 00000000 0000001c fff30313 ffffffff 1
1 1 0 0 00000000 0000001c fff30313 ffffffff 1
1 1 1 0 00000000 00000000 00000013 00000000 0 // flush beats stall
0 0 0 0 00000000 00000020 fe1ff06f ffffffe0 1
0 0 0 0 00000000 00000024 00808067 00000008 1
0 0 0 0 00000000 00000028 00000013 00000000 1 // real nop stays valid
0 0 1 1 00000008 00000000 00000013 00000000 0
0 0 0 0 00000000 00000008 fe112c23 fffffff8 1
0 0 0 0 00000000 0000000c 00412183 00000004 1
0 0 0 0 00000000 00000010 00308663 0000000c 1
0 0 0 0 00000000 00000014 00308233 00000000 1
0 0 0 0 00000000 00000018 00001297 00001000 1
0 0 0 0 00000000 0000001c fff30313 ffffffff 1
0 0 0 0 00000000 00000020 fe1ff06f ffffffe0 1
0 0 1 1 00000000 00000000 00000013 00000000 0
0 0 0 0 00000000 00000000 00500093 00000005 1

// File: program.hex
// one 32 bit word per line starting at byte address 0
// loop with a forward beq to 0x1c and a backward jal to 0x00
00500093 // 00 addi x1, x0, 5
12345137 // 04 lui x2, 0x12345
fe112c23 // 08 sw x1, -8(x2)
00412183 // 0c lw x3, 4(x2)
00308663 // 10 beq x1, x3, +12
00308233 // 14 add x4, x1, x3
00001297 // 18 auipc x5, 0x1
fff30313 // 1c addi x6, x6, -1
fe1ff06f // 20 jal x0, -32
00808067 // 24 jalr x0, 8(x1)
00000013 // 28 nop
00000013
00000013
00000013
00000013
00000013
00000013
00000013
00000013
00000013

// File: rvFrontEnd.f
rvFrontPkg.sv
pcUnit.sv
instructionMemory.sv
fetchDecodeReg.sv
immExtend.sv
rvFrontEnd.sv
rvFrontEnd_tb.sv

// File: run.sh
#!/usr/bin/env bash
# build the front end testbench with Verilator, run it, then look for the pass line

cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing --assert --timescale 1ns/1ps \
    -f rvFrontEnd.f --top-module rvFrontEnd_tb -o simv \
    && ./obj_dir/simv > sim.log 2>&1 \
    || echo "build or simulation ended with an error"

cat sim.log 2>/dev/null
grep -qx "Test OK" sim.log && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }

// File: rvFrontEnd_tb.sv
`timescale 1ns/1ps

module rvFrontEnd_tb import rvFrontPkg::*; ();

    localparam int halfPeriod   = 20;       // 40 ns clock
    localparam int resetCycles  = 5;        // rising edges with rstN low
    localparam int resetTimeout = 20;       // edges allowed for reset to land
    localparam int maxVectors   = 64;
    localparam int minVectors   = 30;       // fewer means a cut-off file

    logic            clk;
    logic            rstN;
    logic            stallF;
    logic            stallD;
    logic            flushD;
    logic            pcSrcE;
    logic [xlen-1:0] pcTargetE;
    logic [xlen-1:0] instrD;
    logic [xlen-1:0] pcD;
    logic [xlen-1:0] pcPlus4D;
    logic [xlen-1:0] immExtD;
    logic            validD;
    logic [xlen-1:0] pcF;

    // vector storage
    logic [3:0]      vecCtrl   [maxVectors]; // stallF stallD flushD pcSrcE
    logic [xlen-1:0] vecTarget [maxVectors];
    logic [xlen-1:0] vecPcD    [maxVectors];
    logic [xlen-1:0] vecInstrD [maxVectors];
    logic [xlen-1:0] vecImm    [maxVectors];
    logic            vecValid  [maxVectors];

    int numVectors;
    int checkCount;
    int mismatchCount;                      // wrong values
    int problemCount;                       // file trouble and timeouts

    rvFrontEnd i_rvFrontEnd (
        .clk       (clk),
        .rstN      (rstN),
        .stallF    (stallF),
        .stallD    (stallD),
        .flushD    (flushD),
        .pcSrcE    (pcSrcE),
        .pcTargetE (pcTargetE),
        .instrD    (instrD),
        .pcD       (pcD),
        .pcPlus4D  (pcPlus4D),
        .immExtD   (immExtD),
        .validD    (validD),
        .pcF       (pcF)
    );

    initial clk = 1'b0;
    always #(halfPeriod) clk = ~clk;

    // reads control inputs and expected decode values, one line per cycle
    task automatic loadVectors();
        int              fd;
        int              code;
        string           line;
        logic [xlen-1:0] sF, sD, fD, pS, tgt, ePc, eInstr, eImm, eValid;
        numVectors = 0;
        fd = $fopen("rvFrontEnd_tests.txt", "r");
        if (fd == 0) begin
            $display("could not open rvFrontEnd_tests.txt");
            problemCount++;
            return;
        end
        while (!$feof(fd) && numVectors < maxVectors) begin
            code = $fgets(line, fd);
            if (code > 0 && line.len() > 1 && line.substr(0, 1) != "//") begin
                code = $sscanf(line, "%h %h %h %h %h %h %h %h %h",
                               sF, sD, fD, pS, tgt, ePc, eInstr, eImm, eValid);
                if (code != 9) begin
                    $display("unreadable line in rvFrontEnd_tests.txt: %s", line);
                    problemCount++;
                end else begin
                    vecCtrl[numVectors]   = {sF[0], sD[0], fD[0], pS[0]};
                    vecTarget[numVectors] = tgt;
                    vecPcD[numVectors]    = ePc;
                    vecInstrD[numVectors] = eInstr;
                    vecImm[numVectors]    = eImm;
                    vecValid[numVectors]  = eValid[0];
                    numVectors++;
                end
            end
        end
        $fclose(fd);
        if (numVectors < minVectors) begin
            $display("rvFrontEnd_tests.txt holds only %0d vectors, at least %0d expected",
                     numVectors, minVectors);
            problemCount++;
        end
    endtask

    task automatic applyVector(input int idx);
        {stallF, stallD, flushD, pcSrcE} = vecCtrl[idx];
        pcTargetE = vecTarget[idx];
    endtask

    // IF/ID must hold a bubble while reset is low
    task automatic checkBubble();
        checkCount += 2;
        assert (validD === 1'b0) else begin
            $display("FAILED validD in reset expected 0 got %h", validD);
            mismatchCount++;
        end
        assert (instrD === nopInstr) else begin
            $display("FAILED instrD in reset expected %h got %h", nopInstr, instrD);
            mismatchCount++;
        end
    endtask

    task automatic checkDecode(input int idx);
        checkCount += 4;
        assert (pcD === vecPcD[idx]) else begin
            $display("FAILED pcD vector %0d expected %h got %h", idx, vecPcD[idx], pcD);
            mismatchCount++;
        end
        assert (instrD === vecInstrD[idx]) else begin
            $display("FAILED instrD vector %0d expected %h got %h",
                     idx, vecInstrD[idx], instrD);
            mismatchCount++;
        end
        assert (immExtD === vecImm[idx]) else begin
            $display("FAILED immExtD vector %0d expected %h got %h", idx, vecImm[idx], immExtD);
            mismatchCount++;
        end
        assert (validD === vecValid[idx]) else begin
            $display("FAILED validD vector %0d expected %h got %h", idx, vecValid[idx], validD);
            mismatchCount++;
        end
        if (vecValid[idx]) begin           // link address of a real word
            checkCount++;
            assert (pcPlus4D === vecPcD[idx] + 32'd4) else begin
                $display("FAILED pcPlus4D vector %0d expected %h got %h",
                         idx, vecPcD[idx] + 32'd4, pcPlus4D);
                mismatchCount++;
            end
        end
    endtask

    initial begin
        int   waitCount;
        int   vecIdx;
        logic resetSeen;
        rstN          = 1'b0;
        stallF        = 1'b0;
        stallD        = 1'b0;
        flushD        = 1'b0;
        pcSrcE        = 1'b0;
        pcTargetE     = '0;
        checkCount    = 0;
        mismatchCount = 0;
        problemCount  = 0;
        loadVectors();

        // sync reset only shows after a clock edge
        waitCount = 0;
        resetSeen = 1'b0;
        while (!resetSeen && waitCount < resetTimeout) begin
            @(posedge clk);
            #(halfPeriod - 1);              // just before the falling edge
            waitCount++;
            resetSeen = (validD === 1'b0) && (instrD === nopInstr) && (pcF === resetPc);
        end
        if (!resetSeen) begin
            $display("timeout: reset did not reach the outputs in %0d cycles", resetTimeout);
            problemCount++;
        end else begin
            while (waitCount < resetCycles) begin   // rest of the reset phase
                @(posedge clk);
                #(halfPeriod - 1);
                waitCount++;
                checkBubble();
            end
            for (vecIdx = 0; vecIdx < numVectors; vecIdx++) begin
                @(negedge clk);
                rstN = 1'b1;                // released with the first vector
                applyVector(vecIdx);
                @(posedge clk);
                #(halfPeriod - 1);
                checkDecode(vecIdx);
            end
        end

        $display("vectors %0d  checks %0d  mismatches %0d  other errors %0d",
                 numVectors, checkCount, mismatchCount, problemCount);
        if (mismatchCount == 0 && problemCount == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

// File: rvFrontEnd.sv
`timescale 1ns/1ps

module rvFrontEnd import rvFrontPkg::*; (
    input  logic            clk,
    input  logic            rstN,           // sync, active low
    input  logic            stallF,         // hazard unit freezes pc
    input  logic            stallD,         // hazard unit freezes IF/ID
    input  logic            flushD,         // hazard unit empties IF/ID
    input  logic            pcSrcE,         // taken branch or jump
    input  logic [xlen-1:0] pcTargetE,      // redirect address
    output logic [xlen-1:0] instrD,
    output logic [xlen-1:0] pcD,
    output logic [xlen-1:0] pcPlus4D,
    output logic [xlen-1:0] immExtD,
    output logic            validD,
    output logic [xlen-1:0] pcF             // current fetch address
);

    logic [xlen-1:0] pcPlus4F;              // fetch successor
    logic [xlen-1:0] instrF;                // rom output

    pcUnit i_pcUnit (
        .clk       (clk),
        .rstN      (rstN),
        .stallF    (stallF),
        .pcSrcE    (pcSrcE),
        .pcTargetE (pcTargetE),
        .pcF       (pcF),
        .pcPlus4F  (pcPlus4F)
    );

    instructionMemory i_instructionMemory (
        .pcF    (pcF),
        .instrF (instrF)
    );

    fetchDecodeReg i_fetchDecodeReg (
        .clk      (clk),
        .rstN     (rstN),
        .stallD   (stallD),
        .flushD   (flushD),
        .instrF   (instrF),
        .pcF      (pcF),
        .pcPlus4F (pcPlus4F),
        .instrD   (instrD),
        .pcD      (pcD),
        .pcPlus4D (pcPlus4D),
        .validD   (validD)
    );

    immExtend i_immExtend (
        .instrD  (instrD),
        .immExtD (immExtD)
    );

endmodule

// File: immExtend.sv
`timescale 1ns/1ps

module immExtend import rvFrontPkg::*; (
    input  logic [xlen-1:0] instrD,         // word in decode
    output logic [xlen-1:0] immExtD         // sign-extended immediate
);

    logic [6:0] opcode;                     // major opcode field
    logic [2:0] immType;                    // selected format
    logic       sign;                       // instr bit 31

    assign opcode = instrD[6:0];
    assign sign   = instrD[31];             // every format signs from bit 31

    // opcode to immediate format
    always_comb begin
        case (opcode)
            opLoad,
            opImm,
            opJalr:   immType = immI;       // rs1 + imm12
            opStore:  immType = immS;
            opBranch: immType = immB;
            opJal:    immType = immJ;
            opLui,
            opAuipc:  immType = immU;
            opReg:    immType = immNone;    // register operands only
            default:  immType = immNone;    // unknown word
        endcase
    end

    // field assembly
    // B and J store the offset in halfwords so bit 0 is always zero
    always_comb begin
        case (immType)
            immI: immExtD = {{20{sign}}, instrD[31:20]};
            immS: immExtD = {{20{sign}}, instrD[31:25], instrD[11:7]};
            immB: immExtD = {{19{sign}}, sign, instrD[7], instrD[30:25],
                             instrD[11:8], 1'b0};          // 13 bit offset
            immJ: immExtD = {{11{sign}}, sign, instrD[19:12], instrD[20],
                             instrD[30:21], 1'b0};         // 21 bit offset
            immU: immExtD = {instrD[31:12], 12'b0};         // upper immediate
            default: begin
                immExtD = '0;               // no immediate
            end
        endcase
    end

    // field map for reference
    // I   imm[11:0]  at 31:20
    // S   imm[11:5]  at 31:25 and imm[4:0] at 11:7
    // B   imm[12] 31, imm[10:5] 30:25, imm[4:1] 11:8, imm[11] 7
    // J   imm[20] 31, imm[10:1] 30:21, imm[11] 20, imm[19:12] 19:12
    // U   imm[31:12] at 31:12

    // the nop bubble is an opImm word with a zero field
    // so a flushed slot gives immExtD of zero

endmodule

// File: fetchDecodeReg.sv
`timescale 1ns/1ps

module fetchDecodeReg import rvFrontPkg::*; (
    input  logic            clk,
    input  logic            rstN,           // sync, active low
    input  logic            stallD,         // hold decode stage
    input  logic            flushD,         // kill the fetched word
    input  logic [xlen-1:0] instrF,         // from rom
    input  logic [xlen-1:0] pcF,            // fetch address
    input  logic [xlen-1:0] pcPlus4F,       // fetch address + 4
    output logic [xlen-1:0] instrD,         // word in decode
    output logic [xlen-1:0] pcD,            // its address
    output logic [xlen-1:0] pcPlus4D,       // its link address
    output logic            validD          // low for a bubble
);

    // IF/ID register
    // flush is checked first so a wrong-path word
    // cannot sit in decode while the stage is stalled
    always_ff @(posedge clk) begin
        if (!rstN) begin
            instrD   <= nopInstr;           // start with a bubble
            pcD      <= '0;
            pcPlus4D <= '0;
            validD   <= 1'b0;
        end else if (flushD) begin
            instrD   <= nopInstr;           // squash wrong path
            pcD      <= '0;
            pcPlus4D <= '0;
            validD   <= 1'b0;
        end else if (!stallD) begin
            instrD   <= instrF;             // normal advance
            pcD      <= pcF;
            pcPlus4D <= pcPlus4F;
            validD   <= 1'b1;
        end
        // stallD alone keeps everything
    end

    // a flushed slot never reaches decode as valid
    flushBubble: assert property (
        @(posedge clk) disable iff (!rstN)
        flushD |=> !validD
    ) else $error("validD high after flush");

endmodule

// File: instructionMemory.sv
`timescale 1ns/1ps

module instructionMemory import rvFrontPkg::*; (
    input  logic [xlen-1:0] pcF,            // byte address from fetch
    output logic [xlen-1:0] instrF          // instruction word
);

    logic [xlen-1:0]     rom [imemDepth];   // program image
    logic [imemIdxW-1:0] wordIdx;           // word index into rom

    // image is fixed at build time
    initial begin
        $readmemh("program.hex", rom);      // one word per line
    end

    // drop the two byte offset bits
    assign wordIdx = pcF[imemIdxW+1:2];

    // combinational read
    // same cycle as the pc
    always_comb begin
        instrF = rom[wordIdx];
    end

    // no clock here, so the range check runs on every change of pcF
    // upper bits set would alias back into the rom
    always_comb begin
        if (!$isunknown(pcF)) begin
            pcInRom: assert (pcF[xlen-1:imemIdxW+2] == '0)
                else $error("pc %h outside rom", pcF);
        end
    end

    // word alignment is guarded at the pc register
    // so the two low bits are simply ignored here

    // rom size is imemDepth words
    // which covers byte addresses 0 up to 4*imemDepth-4

endmodule

// File: pcUnit.sv
`timescale 1ns/1ps

module pcUnit import rvFrontPkg::*; (
    input  logic            clk,
    input  logic            rstN,           // sync, active low
    input  logic            stallF,         // freeze fetch
    input  logic            pcSrcE,         // redirect strobe from execute
    input  logic [xlen-1:0] pcTargetE,      // branch or jump target
    output logic [xlen-1:0] pcF,            // current fetch address
    output logic [xlen-1:0] pcPlus4F        // sequential next address
);

    logic [xlen-1:0] pcNext;                // value loaded at the next edge

    // sequential successor
    assign pcPlus4F = pcF + 32'd4;          // plain word step

    // next pc selection
    // a taken branch from execute must not be lost
    // while the fetch stage is frozen by a load hazard
    always_comb begin
        if (pcSrcE) begin
            pcNext = pcTargetE;             // redirect beats stall
        end else if (stallF) begin
            pcNext = pcF;                   // hold on stall
        end else begin
            pcNext = pcPlus4F;              // normal fetch
        end
    end

    // pc register
    always_ff @(posedge clk) begin
        if (!rstN) begin
            pcF <= resetPc;                 // start of program
        end else begin
            pcF <= pcNext;
        end
    end

    // target from execute is always a word address
    // since the rom has no misaligned fetch path
    pcTargetAligned: assert property (
        @(posedge clk) disable iff (!rstN)
        pcSrcE |-> (pcTargetE[1:0] == 2'b00)
    ) else $error("misaligned redirect target %h", pcTargetE);

endmodule

// File: rvFrontPkg.sv
package rvFrontPkg;

    // datapath widths
    localparam int xlen      = 32;                  // data, address and instruction width
    localparam int imemDepth = 256;                 // rom words
    localparam int imemIdxW  = $clog2(imemDepth);   // word index bits

    // reset and bubble values
    localparam logic [xlen-1:0] resetPc  = 32'h0000_0000;   // first fetch address
    localparam logic [xlen-1:0] nopInstr = 32'h0000_0013;   // addi x0, x0, 0

    // major opcodes in instr[6:0]
    localparam logic [6:0] opLoad   = 7'b0000011;   // lb lh lw lbu lhu
    localparam logic [6:0] opImm    = 7'b0010011;   // addi slti andi slli and friends
    localparam logic [6:0] opStore  = 7'b0100011;   // sb sh sw
    localparam logic [6:0] opBranch = 7'b1100011;   // beq bne blt bge bltu bgeu
    localparam logic [6:0] opJal    = 7'b1101111;   // jal
    localparam logic [6:0] opJalr   = 7'b1100111;   // jalr
    localparam logic [6:0] opLui    = 7'b0110111;   // lui
    localparam logic [6:0] opAuipc  = 7'b0010111;   // auipc
    localparam logic [6:0] opReg    = 7'b0110011;   // add sub and or and friends

    // immediate format selected by the extender
    localparam logic [2:0] immI    = 3'b000;        // 12 bit signed
    localparam logic [2:0] immS    = 3'b001;        // split store offset
    localparam logic [2:0] immB    = 3'b010;        // branch offset in halfwords
    localparam logic [2:0] immJ    = 3'b011;        // jump offset in halfwords
    localparam logic [2:0] immU    = 3'b100;        // upper twenty bits
    localparam logic [2:0] immNone = 3'b111;        // r type and unknown opcodes

    // the front end keeps the whole 32 bit word
    // through IF/ID and the decode stage
    // picks the fields apart itself

    // index math
    // byte address 4*k maps to rom word k
    // bits above the index must stay zero

    // bubble handling
    // nopInstr is loaded on reset and on flush
    // so decode sees a harmless addi

    // back-pressure
    // stallF holds the pc
    // stallD holds IF/ID
    // flushD empties IF/ID

endpackage
